// ==== controlPkg.sv ====
`default_nettype none

package controlPkg;

	// datapath widths
	localparam int instrWidth = 32;
	localparam int dataWidth = 64;

	typedef logic [4:0] regAddr_t; // register file address
	typedef logic [4:0] funcSel_t; // {op[2:0], invert a, invert b}
	typedef logic [1:0] pcSel_t;
	typedef logic [1:0] busSel_t;
	typedef logic [3:0] statusFlags_t; // {V, C, Z, N}

	// alu operations, bits 4..2 pick the unit
	localparam funcSel_t fsAnd = 5'b00000;
	localparam funcSel_t fsOr = 5'b00100;
	localparam funcSel_t fsAdd = 5'b01000;
	localparam funcSel_t fsXor = 5'b01100;
	localparam funcSel_t fsShiftLeft = 5'b10000;
	localparam funcSel_t fsShiftRight = 5'b10100;

	// next pc source
	localparam pcSel_t psHold = 2'b00; // pc keeps its value
	localparam pcSel_t psNext = 2'b01; // pc + 4
	localparam pcSel_t psRegister = 2'b10; // pc from register or constant
	localparam pcSel_t psRelative = 2'b11; // pc + 4 + k * 4

	// what drives the data bus
	localparam busSel_t busAlu = 2'b00;
	localparam busSel_t busRam = 2'b01;
	localparam busSel_t busPc4 = 2'b10;
	localparam busSel_t busB = 2'b11; // store data path

	localparam regAddr_t zeroReg = 5'd31; // reads as zero

	localparam int fifoDepth = 2;
	localparam int opGroupBit = 26; // set for branch group

	// 93 bits, control fields then constant
	typedef struct packed {
		regAddr_t da;
		regAddr_t sa;
		regAddr_t sb;
		funcSel_t fs;
		pcSel_t ps;
		busSel_t busSel;
		logic regWrite;
		logic memWrite;
		logic pcSelA; // pc input from a instead of k
		logic bSelB; // alu b from register instead of k
		logic statusLoad;
		logic [dataWidth-1:0] k;
	} controlWord_t;

endpackage

`default_nettype wire

// ==== instrIntake.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrIntake import controlPkg::*; (
	input wire clock,
	input wire rst,
	input wire [instrWidth-1:0] instr,
	input wire statusFlags_t status,
	input wire zero,
	input wire instrReq,
	input wire take, // word accepted by the fifo
	output logic instrAck,
	output logic [instrWidth-1:0] heldInstr,
	output statusFlags_t heldStatus,
	output logic heldZero,
	output logic heldValid
);

	logic capture;

	// only a fresh request into an empty holder
	assign capture = instrReq && !instrAck && !heldValid;

	always_ff @(posedge clock) begin
		if (rst) begin
			instrAck <= 1'b0;
			heldValid <= 1'b0;
		end else begin
			if (capture) begin
				instrAck <= 1'b1;
				heldValid <= 1'b1;
			end else if (take) begin
				heldValid <= 1'b0; // slot free again
			end
			if (instrAck && !instrReq)
				instrAck <= 1'b0; // return to zero phase
		end
	end

	// instruction and flags held as one snapshot
	always_ff @(posedge clock) begin
		if (capture) begin
			heldInstr <= instr;
			heldStatus <= status;
			heldZero <= zero;
		end
	end

	// ack only answers a live request
	ackNeedsReq: assert property (@(posedge clock) disable iff (rst)
		!instrAck && !instrReq |=> !instrAck);

endmodule

`default_nettype wire

// ==== aluDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluDecode import controlPkg::*; (
	input wire [instrWidth-1:0] instr,
	output controlWord_t word
);

	logic [2:0] fmt; // opcode bits 25..23
	funcSel_t rFunc; // r-format alu select

	assign fmt = instr[25:23];

	always_comb begin
		if (instr[22]) begin
			rFunc = instr[21] ? fsShiftLeft : fsShiftRight; // lsl / lsr
		end else if (instr[27]) begin
			rFunc = fsAdd | funcSel_t'(instr[30]); // sub inverts b
		end else begin
			case ({instr[30], instr[29]})
				2'b01: rFunc = fsOr;
				2'b10: rFunc = fsXor;
				default: rFunc = fsAnd; // and, ands
			endcase
		end
	end

	always_comb begin
		word = '0;
		word.ps = psHold; // unknown slot stalls the pc
		case (fmt)
			3'b000: begin
				// ldur / stur
				word.da = instr[4:0];
				word.sa = instr[9:5]; // base register
				word.sb = instr[4:0]; // store data
				word.fs = fsAdd; // base + offset
				word.ps = psNext;
				word.busSel = instr[22] ? busRam : busB;
				word.regWrite = instr[22];
				word.memWrite = !instr[22];
				word.k = dataWidth'(instr[20:12]); // 9 bit offset
			end
			3'b010: begin
				// addi / subi, optional flags
				word.da = instr[4:0];
				word.sa = instr[9:5];
				word.sb = zeroReg;
				word.fs = fsAdd | funcSel_t'(instr[30]);
				word.ps = psNext;
				word.busSel = busAlu;
				word.regWrite = 1'b1;
				word.statusLoad = instr[29];
				word.k = dataWidth'(instr[21:10]); // 12 bit immediate
			end
			3'b110: begin
				word.da = instr[4:0];
				word.sa = instr[9:5];
				word.sb = instr[20:16];
				word.fs = rFunc;
				word.ps = psNext;
				word.busSel = busAlu;
				word.regWrite = 1'b1;
				word.bSelB = !instr[22]; // shifts take shamt from k
				word.statusLoad = (instr[30] & instr[29]) | (!instr[30] & instr[29] & instr[24]);
				word.k = dataWidth'(instr[15:10]); // shift amount
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== branchDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module branchDecode import controlPkg::*; (
	input wire [instrWidth-1:0] instr,
	input wire statusFlags_t status,
	input wire zero,
	output controlWord_t word
);

	logic [2:0] fmt; // opcode bits 31..29
	logic v, c, z, n;
	logic baseCond; // eq ne cs cc mi pl vs vc
	logic extCond; // hi ls ge lt gt le al al
	logic taken;
	logic [dataWidth-1:0] condK; // 19 bit offset

	assign fmt = instr[31:29];
	assign {v, c, z, n} = status;
	assign condK = dataWidth'($signed(instr[23:5]));

	always_comb begin
		case (instr[2:1])
			2'b00: baseCond = z;
			2'b01: baseCond = c;
			2'b10: baseCond = n;
			default: baseCond = v;
		endcase
		case (instr[2:0])
			3'd0: extCond = c & !z; // hi
			3'd1: extCond = !c | z; // ls
			3'd2: extCond = n == v; // ge
			3'd3: extCond = n != v; // lt
			3'd4: extCond = !z && (n == v); // gt
			3'd5: extCond = z || (n != v); // le
			default: extCond = 1'b1;
		endcase
		taken = instr[3] ? extCond : baseCond ^ instr[0]; // bit 0 negates low codes
	end

	always_comb begin
		word = '0;
		word.ps = psHold;
		case (fmt)
			3'b000: begin
				// b
				word.da = zeroReg;
				word.sa = zeroReg;
				word.sb = zeroReg;
				word.ps = psRelative;
				word.busSel = busPc4;
				word.k = dataWidth'($signed(instr[25:0]));
			end
			3'b010: begin
				// b.cond on latched flags
				word.da = zeroReg;
				word.sa = zeroReg;
				word.sb = zeroReg;
				word.ps = taken ? psRelative : psNext;
				word.busSel = busPc4;
				word.k = condK;
			end
			3'b101: begin
				// cbz / cbnz, bit 24 picks nonzero test
				word.da = zeroReg;
				word.sa = instr[4:0]; // register under test
				word.sb = zeroReg;
				word.fs = fsAdd; // pass a through the alu
				word.ps = (instr[24] ^ zero) ? psRelative : psNext;
				word.busSel = busPc4;
				word.bSelB = 1'b1;
				word.k = condK;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== cwFifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module cwFifo import controlPkg::*; (
	input wire clock,
	input wire rst,
	input wire push,
	input wire controlWord_t pushWord,
	input wire pop,
	output controlWord_t popWord,
	output logic full,
	output logic empty
);

	typedef logic [$clog2(fifoDepth)-1:0] ptr_t;
	typedef logic [$clog2(fifoDepth+1)-1:0] count_t;

	controlWord_t mem [fifoDepth];
	ptr_t wrPtr;
	ptr_t rdPtr;
	count_t count; // words held

	assign full = count == count_t'(fifoDepth);
	assign empty = count == '0;
	assign popWord = mem[rdPtr]; // head visible without a read cycle

	always_ff @(posedge clock) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push)
				wrPtr <= (wrPtr == ptr_t'(fifoDepth - 1)) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (rdPtr == ptr_t'(fifoDepth - 1)) ? '0 : rdPtr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ; // both or neither
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (push)
			mem[wrPtr] <= pushWord;
	end

	// intake gating must respect full and issue must respect empty
	noOverflow: assert property (@(posedge clock) disable iff (rst) push |-> !full);
	noUnderflow: assert property (@(posedge clock) disable iff (rst) pop |-> !empty);

endmodule

`default_nettype wire

// ==== cwIssue.sv ====
`timescale 1ns/1ps
`default_nettype none

module cwIssue import controlPkg::*; (
	input wire clock,
	input wire rst,
	input wire empty,
	input wire controlWord_t popWord,
	input wire cwAck,
	output logic pop,
	output regAddr_t da,
	output regAddr_t sa,
	output regAddr_t sb,
	output funcSel_t fs,
	output pcSel_t ps,
	output busSel_t busSel,
	output logic regWrite,
	output logic memWrite,
	output logic pcSelA,
	output logic bSelB,
	output logic statusLoad,
	output logic [dataWidth-1:0] k,
	output logic cwReq
);

	controlWord_t wordReg; // word on the wires
	logic waitLow; // ack still high from last transfer

	assign pop = !empty && !cwReq && !waitLow;
	assign {da, sa, sb, fs, ps, busSel, regWrite, memWrite, pcSelA, bSelB, statusLoad, k} = wordReg;

	always_ff @(posedge clock) begin
		if (rst) begin
			cwReq <= 1'b0;
			waitLow <= 1'b0;
		end else if (pop) begin
			cwReq <= 1'b1;
		end else if (cwReq && cwAck) begin
			cwReq <= 1'b0;
			waitLow <= 1'b1;
		end else if (waitLow && !cwAck) begin
			waitLow <= 1'b0; // handshake complete
		end
	end

	always_ff @(posedge clock) begin
		if (pop)
			wordReg <= popWord;
	end

	// fields and req hold until the datapath acks
	holdUntilAck: assert property (@(posedge clock) disable iff (rst)
		cwReq && !cwAck |=> cwReq && $stable(wordReg));

endmodule

`default_nettype wire

// ==== controlUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlUnit import controlPkg::*; (
	input wire clock,
	input wire rst,
	input wire [instrWidth-1:0] instr,
	input wire statusFlags_t status,
	input wire zero, // register zero test for cbz
	input wire instrReq,
	input wire cwAck,
	output logic instrAck,
	output regAddr_t da,
	output regAddr_t sa,
	output regAddr_t sb,
	output funcSel_t fs,
	output pcSel_t ps,
	output busSel_t busSel,
	output logic regWrite,
	output logic memWrite,
	output logic pcSelA,
	output logic bSelB,
	output logic statusLoad,
	output logic [dataWidth-1:0] k,
	output logic cwReq
);

	logic [instrWidth-1:0] heldInstr;
	statusFlags_t heldStatus;
	logic heldZero;
	logic heldValid;
	controlWord_t aluWord;
	controlWord_t brWord;
	controlWord_t decWord;
	controlWord_t popWord;
	logic push, pop, full, empty;

	assign decWord = heldInstr[opGroupBit] ? brWord : aluWord; // branch vs alu group
	assign push = heldValid && !full; // also frees the intake

	instrIntake intake0 (.clock, .rst, .instr, .status, .zero, .instrReq,
		.take(push), .instrAck, .heldInstr, .heldStatus, .heldZero, .heldValid);

	aluDecode aluDec0 (.instr(heldInstr), .word(aluWord));

	branchDecode brDec0 (.instr(heldInstr), .status(heldStatus), .zero(heldZero), .word(brWord));

	cwFifo fifo0 (.clock, .rst, .push, .pushWord(decWord), .pop, .popWord, .full, .empty);

	cwIssue issue0 (.clock, .rst, .empty, .popWord, .cwAck, .pop, .da, .sa, .sb, .fs, .ps,
		.busSel, .regWrite, .memWrite, .pcSelA, .bSelB, .statusLoad, .k, .cwReq);

endmodule

`default_nettype wire

// ==== tbClock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
	parameter int resetCycles = 16
) (
	output logic clock,
	output logic rst
);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock; // 100 ns period
	end

	initial begin
		rst = 1'b1;
		repeat (resetCycles) @(posedge clock);
		#1 rst = 1'b0; // released just after an edge like the other inputs
	end

endmodule

`default_nettype wire

// ==== tbControlUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbControlUnit import controlPkg::*; ();

	localparam int numPats = 36;
	localparam int numCols = 15; // instr, status, zero, then 12 expected fields
	localparam int resetCycles = 16;

	logic clock, rst;
	logic [instrWidth-1:0] instr;
	statusFlags_t status;
	logic zero, instrReq, instrAck, cwAck, cwReq;
	regAddr_t da, sa, sb;
	funcSel_t fs;
	pcSel_t ps;
	busSel_t busSel;
	logic regWrite, memWrite, pcSelA, bSelB, statusLoad;
	logic [dataWidth-1:0] k;

	logic [63:0] pats [numPats*numCols];
	int sentCount = 0; // instructions acked by the intake
	int doneCount = 0; // words whose output handshake finished
	logic ackPrev = 1'b0;
	logic reqPrev = 1'b0;

	tbClock #(.resetCycles(resetCycles)) clk0 (.clock, .rst);

	controlUnit dut0 (.clock, .rst, .instr, .status, .zero, .instrReq, .cwAck, .instrAck,
		.da, .sa, .sb, .fs, .ps, .busSel, .regWrite, .memWrite, .pcSelA, .bSelB,
		.statusLoad, .k, .cwReq);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic abortRun(input string what);
		$display("%s", what);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic checkField(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp) else
			abortRun($sformatf("error %s got %h expected %h", name, got, exp));
	endtask

	// fields compared in control word order
	task automatic checkWord(input int idx);
		int b;
		b = idx * numCols;
		checkField("da", 64'(da), pats[b+3]);
		checkField("sa", 64'(sa), pats[b+4]);
		checkField("sb", 64'(sb), pats[b+5]);
		checkField("fs", 64'(fs), pats[b+6]);
		checkField("ps", 64'(ps), pats[b+7]);
		checkField("busSel", 64'(busSel), pats[b+8]);
		checkField("regWrite", 64'(regWrite), pats[b+9]);
		checkField("memWrite", 64'(memWrite), pats[b+10]);
		checkField("pcSelA", 64'(pcSelA), pats[b+11]);
		checkField("bSelB", 64'(bSelB), pats[b+12]);
		checkField("statusLoad", 64'(statusLoad), pats[b+13]);
		checkField("k", k, pats[b+14]);
	endtask

	// producer side of the intake handshake
	initial begin : driveInput
		logic [31:0] rng;
		int base;
		rng = 32'd12049;
		instr = '0;
		status = '0;
		zero = 1'b0;
		instrReq = 1'b0;
		$readmemh("controlPatterns.txt", pats);
		repeat (resetCycles + 2) begin
			@(negedge clock); // both handshakes quiet through reset and just after
			assert (!instrAck && !cwReq) else
				abortRun("a handshake line was high during or right after reset");
		end
		@(posedge clock);
		#1;
		for (int i = 0; i < numPats; i++) begin
			rng = xorshift(rng);
			repeat (rng[1:0]) begin
				@(posedge clock);
				#1;
			end
			base = i * numCols;
			instr = pats[base][31:0];
			status = pats[base+1][3:0];
			zero = pats[base+2][0];
			instrReq = 1'b1;
			do begin
				@(posedge clock);
				#1;
			end while (!instrAck); // held off while the unit is full
			instrReq = 1'b0;
			do begin
				@(posedge clock);
				#1;
			end while (instrAck);
		end
	end

	// datapath side, slow acks build back-pressure
	initial begin : takeOutput
		logic [31:0] rng;
		int ackDelay;
		rng = 32'd12049;
		cwAck = 1'b0;
		@(negedge rst);
		for (int i = 0; i < numPats; i++) begin
			do begin
				@(posedge clock);
				#1;
			end while (!cwReq);
			checkWord(i); // arrival order must match file order
			rng = xorshift(rng);
			ackDelay = (rng[4:3] == 2'b00) ? 20 + int'(rng[12:8]) : int'(rng[1:0]);
			repeat (ackDelay) begin
				@(posedge clock);
				#1;
			end
			cwAck = 1'b1;
			do begin
				@(posedge clock);
				#1;
			end while (cwReq);
			cwAck = 1'b0;
		end
		repeat (10) begin
			@(negedge clock);
			assert (!cwReq) else
				abortRun("an extra control word came out after the last pattern");
		end
		$display("No errors");
		$finish;
	end

	// occupancy bookkeeping, intake + fifo + issue hold at most four
	always @(negedge clock) begin
		if (!rst) begin
			if (instrAck && !ackPrev)
				sentCount++;
			if (cwReq && !reqPrev) begin
				assert (sentCount > doneCount) else
					abortRun("a control word came out with no instruction outstanding");
			end
			if (!cwReq && reqPrev)
				doneCount++;
			assert (sentCount - doneCount <= 4) else
				abortRun("an instruction was accepted while the unit was full");
		end
		ackPrev <= instrAck;
		reqPrev <= cwReq;
	end

	initial begin : watchdog
		repeat (resetCycles + numPats * 200) @(posedge clock);
		abortRun("the run timed out waiting for a handshake");
	end

endmodule

`default_nettype wire

// ==== controlPatterns.txt ====
// instr status zero | expected: da sa sb fs ps busSel regWrite memWrite pcSelA bSelB
// statusLoad k
F85A50A3 0 0 03 05 03 08 1 1 1 0 0 0 0 00000000000001A5
F80FF047 5 1 07 02 07 08 1 3 0 1 0 0 0 00000000000000FF
91048C41 0 0 01 02 1F 08 1 0 1 0 0 0 0 0000000000000123
F13FFD49 0 0 09 0A 1F 09 1 0 1 0 0 0 1 0000000000000FFF
AB054483 0 0 03 04 05 08 1 0 1 0 0 1 1 0000000000000011
CB0800E6 0 0 06 07 08 09 1 0 1 0 0 1 0 0000000000000000
830CFD6A 0 0 0A 0B 0C 00 1 0 1 0 0 1 0 000000000000003F
A30F01CD 0 0 0D 0E 0F 04 1 0 1 0 0 1 1 0000000000000000
C3120230 0 0 10 11 12 0C 1 0 1 0 0 1 0 0000000000000000
D3601693 0 0 13 14 00 10 1 0 1 0 0 0 0 0000000000000005
D340FED5 0 0 15 16 00 14 1 0 1 0 0 0 0 000000000000003F
17FFFFF0 3 0 1F 1F 1F 00 3 2 0 0 0 0 0 FFFFFFFFFFFFFFF0
14001234 C 1 1F 1F 1F 00 3 2 0 0 0 0 0 0000000000001234
54002000 2 0 1F 1F 1F 00 3 2 0 0 0 0 0 0000000000000100
54FFE021 2 1 1F 1F 1F 00 1 2 0 0 0 0 0 FFFFFFFFFFFFFF01
54002042 0 0 1F 1F 1F 00 1 2 0 0 0 0 0 0000000000000102
54FFE063 0 1 1F 1F 1F 00 3 2 0 0 0 0 0 FFFFFFFFFFFFFF03
54002084 1 0 1F 1F 1F 00 3 2 0 0 0 0 0 0000000000000104
54FFE0A5 1 0 1F 1F 1F 00 1 2 0 0 0 0 0 FFFFFFFFFFFFFF05
540020C6 8 0 1F 1F 1F 00 3 2 0 0 0 0 0 0000000000000106
54FFE0E7 7 0 1F 1F 1F 00 3 2 0 0 0 0 0 FFFFFFFFFFFFFF07
54002108 4 0 1F 1F 1F 00 3 2 0 0 0 0 0 0000000000000108
54FFE129 4 0 1F 1F 1F 00 1 2 0 0 0 0 0 FFFFFFFFFFFFFF09
5400214A 9 0 1F 1F 1F 00 3 2 0 0 0 0 0 000000000000010A
54FFE16B 9 0 1F 1F 1F 00 1 2 0 0 0 0 0 FFFFFFFFFFFFFF0B
5400218C B 0 1F 1F 1F 00 1 2 0 0 0 0 0 000000000000010C
54FFE1AD 8 0 1F 1F 1F 00 3 2 0 0 0 0 0 FFFFFFFFFFFFFF0D
540021CE 0 0 1F 1F 1F 00 3 2 0 0 0 0 0 000000000000010E
54FFE1EF F 1 1F 1F 1F 00 3 2 0 0 0 0 0 FFFFFFFFFFFFFF0F
B4000404 0 1 1F 04 1F 08 3 2 0 0 0 1 0 0000000000000020
B4FFFFE9 0 0 1F 09 1F 08 1 2 0 0 0 1 0 FFFFFFFFFFFFFFFF
B57FFFE2 0 0 1F 02 1F 08 3 2 0 0 0 1 0 000000000003FFFF
B580001E 0 1 1F 1E 1F 08 1 2 0 0 0 1 0 FFFFFFFFFFFC0000
D2801234 0 0 00 00 00 00 0 0 0 0 0 0 0 0000000000000000
94000010 6 1 00 00 00 00 0 0 0 0 0 0 0 0000000000000000
D61F03C0 0 0 00 00 00 00 0 0 0 0 0 0 0 0000000000000000

// ==== flist.f ====
controlPkg.sv
instrIntake.sv
aluDecode.sv
branchDecode.sv
cwFifo.sv
cwIssue.sv
controlUnit.sv
tbClock.sv
tbControlUnit.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tbControlUnit \
	-f flist.f -o tbControlUnit
out=$(./obj_dir/tbControlUnit 2>&1) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx 'No errors'; then
	exit 0
fi
exit 1
